// File: include/frontend_params.svh
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// ----------------------------------------------------------------------
// frontend sizing constants
// ----------------------------------------------------------------------

// address and instruction width, RV32I only
`define FE_XLEN 32

// fetch queue slots towards decode
// keep this a power of two, the pointers wrap naturally
`define FE_QUEUE_DEPTH 4

// number of 2-bit counters in the branch history table
// indexed by the pc bits just above the word offset
`define FE_BHT_ENTRIES 16

`endif

// File: hdl/frontend_pkg.sv
`default_nettype none

`include "frontend_params.svh"

package frontend_pkg;

    // ------------------------------------------------------------------
    // basic vectors
    // ------------------------------------------------------------------
    typedef logic [`FE_XLEN-1:0] addr_t;
    typedef logic [`FE_XLEN-1:0] instr_t;
    typedef logic [$clog2(`FE_BHT_ENTRIES)-1:0] bht_idx_t;

    // control flow class found by the scanner
    typedef enum logic [1:0] {
        NO_CF  = 2'd0,
        BRANCH = 2'd1,
        JUMP   = 2'd2,
        JUMPR  = 2'd3
    } cf_e;

    // ------------------------------------------------------------------
    // instruction memory handshake
    // ------------------------------------------------------------------
    typedef struct packed {
        logic  req;
        addr_t vaddr;
    } mem_req_t;

    typedef struct packed {
        logic   ready;
        logic   valid;
        instr_t data;
    } mem_rsp_t;

    // resolved control flow coming back from execute
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t target;
        logic  is_taken;
        logic  is_mispredict;
        cf_e   cf_type;
    } bp_resolve_t;

    // one instruction handed to decode
    typedef struct packed {
        addr_t  address;
        instr_t instr;
        cf_e    cf_type;
        logic   predict_taken;
        addr_t  predict_address;
    } fetch_entry_t;

    // scanner result, imm already sign extended
    typedef struct packed {
        cf_e   cf_type;
        addr_t imm;
    } scan_t;

    // counter write towards the bht
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
    } bht_update_t;

endpackage

`default_nettype wire

// File: hdl/instr_scan.sv
`timescale 1ns/1ns
`default_nettype none

module instr_scan (
    input  frontend_pkg::instr_t instr_i,
    output frontend_pkg::scan_t  scan_o
);
    import frontend_pkg::*;

    // ------------------------------------------------------------------
    // opcode decode
    // ------------------------------------------------------------------
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    addr_t      imm_j;
    addr_t      imm_b;
    addr_t      imm_i;

    assign opcode = instr_i[6:0];

    // j-type offset, bit 0 is always zero
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // b-type offset, sign bit drives the static prediction
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    // i-type offset of jalr, target unknown here so only reported
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        scan_o.cf_type = NO_CF;
        scan_o.imm     = '0;
        unique case (opcode)
            OPC_JAL: begin
                scan_o.cf_type = JUMP;
                scan_o.imm     = imm_j;
            end
            OPC_JALR: begin
                scan_o.cf_type = JUMPR;
                scan_o.imm     = imm_i;
            end
            OPC_BRANCH: begin
                scan_o.cf_type = BRANCH;
                scan_o.imm     = imm_b;
            end
            // plain instruction, no control flow
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/bht.sv
`timescale 1ns/1ns
`default_nettype none

`include "frontend_params.svh"

module bht (
    input  logic                      clk_i,
    input  logic                      npc_rst_load_q,
    input  logic                      flush_i,
    input  frontend_pkg::addr_t       vpc_i,
    input  frontend_pkg::bht_update_t update_i,
    output logic                      taken_o,
    output logic                      valid_o
);
    import frontend_pkg::*;

    // ------------------------------------------------------------------
    // counter storage
    // ------------------------------------------------------------------
    // counters carry no reset, the valid bit says whether they hold history
    logic [1:0]                cnt_q   [`FE_BHT_ENTRIES];
    logic [`FE_BHT_ENTRIES-1:0] valid_q;

    bht_idx_t rd_idx;
    bht_idx_t wr_idx;
    logic [1:0] cnt_upd;

    // word aligned pc, skip bits 1:0
    assign rd_idx = vpc_i[$bits(bht_idx_t)+1:2];
    assign wr_idx = update_i.pc[$bits(bht_idx_t)+1:2];

    // read side, purely combinational
    assign taken_o = cnt_q[rd_idx][1];
    assign valid_o = valid_q[rd_idx];

    // ------------------------------------------------------------------
    // counter update
    // ------------------------------------------------------------------
    always_comb begin
        cnt_upd = cnt_q[wr_idx];
        if (!valid_q[wr_idx]) begin
            // first sighting, start weak in the observed direction
            cnt_upd = update_i.taken ? 2'b10 : 2'b01;
        end else if (update_i.taken) begin
            if (cnt_upd != 2'b11) cnt_upd = cnt_upd + 2'b01;
        end else begin
            if (cnt_upd != 2'b00) cnt_upd = cnt_upd - 2'b01;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            cnt_q[wr_idx] <= cnt_upd;
        end
    end

    // history is forgotten on reset and on a pipeline flush
    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q || flush_i) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "frontend_params.svh"

module pc_gen (
    input  logic                       clk_i,
    input  logic                       npc_rst_load_q,
    input  logic                       flush_i,
    input  frontend_pkg::addr_t        boot_addr_i,
    input  frontend_pkg::bp_resolve_t  resolved_branch_i,
    input  logic                       set_pc_commit_i,
    input  frontend_pkg::addr_t        pc_commit_i,
    input  logic                       eret_i,
    input  frontend_pkg::addr_t        epc_i,
    input  logic                       ex_valid_i,
    input  frontend_pkg::addr_t        trap_vector_base_i,
    output frontend_pkg::mem_req_t     mem_req_o,
    input  frontend_pkg::mem_rsp_t     mem_rsp_i,
    input  frontend_pkg::scan_t        scan_i,
    input  logic                       bht_taken_i,
    input  logic                       bht_valid_i,
    input  logic                       queue_space_i,
    output frontend_pkg::addr_t        fetch_addr_o,
    output frontend_pkg::instr_t       fetch_instr_o,
    output logic                       push_o,
    output frontend_pkg::fetch_entry_t push_entry_o,
    output frontend_pkg::bht_update_t  bht_update_o
);
    import frontend_pkg::*;

    // npc_q is the address being fetched, or the next one to fetch
    addr_t npc_d, npc_q;
    logic  run_q;
    logic  outstanding_d, outstanding_q;
    logic  stale_d, stale_q;
    logic  accept, rsp_fire, fresh, mispredict, kill;
    logic  predict_taken;
    addr_t predict_address;

    // ------------------------------------------------------------------
    // memory handshake
    // ------------------------------------------------------------------
    // one request in flight at most, and only with room for its answer
    assign mem_req_o.req   = run_q && !outstanding_q && queue_space_i;
    assign mem_req_o.vaddr = npc_q;
    assign accept   = mem_req_o.req && mem_rsp_i.ready;
    assign rsp_fire = outstanding_q && mem_rsp_i.valid;
    assign fresh    = rsp_fire && !stale_q;

    assign mispredict = resolved_branch_i.valid && resolved_branch_i.is_mispredict;
    // anything that throws away the fetch stream
    assign kill = flush_i || set_pc_commit_i || ex_valid_i || eret_i || mispredict;

    // returned word goes to scan and bht together with its address
    assign fetch_addr_o  = npc_q;
    assign fetch_instr_o = mem_rsp_i.data;

    // ------------------------------------------------------------------
    // prediction
    // ------------------------------------------------------------------
    always_comb begin
        unique case (scan_i.cf_type)
            JUMP:    predict_taken = 1'b1;
            // no history: backward taken, forward not taken
            BRANCH:  predict_taken = bht_valid_i ? bht_taken_i
                                                 : scan_i.imm[`FE_XLEN-1];
            // jalr has no target source without a btb
            default: predict_taken = 1'b0;
        endcase
    end

    assign predict_address = predict_taken ? npc_q + scan_i.imm : npc_q + addr_t'(4);

    assign push_o                       = fresh && !kill;
    assign push_entry_o.address         = npc_q;
    assign push_entry_o.instr           = mem_rsp_i.data;
    assign push_entry_o.cf_type         = scan_i.cf_type;
    assign push_entry_o.predict_taken   = predict_taken;
    assign push_entry_o.predict_address = predict_address;

    // train only on conditional branches
    assign bht_update_o.valid = resolved_branch_i.valid && (resolved_branch_i.cf_type == BRANCH);
    assign bht_update_o.pc    = resolved_branch_i.pc;
    assign bht_update_o.taken = resolved_branch_i.is_taken;

    // ------------------------------------------------------------------
    // next pc, highest priority first
    // ------------------------------------------------------------------
    always_comb begin
        npc_d = npc_q;
        if (set_pc_commit_i)  npc_d = pc_commit_i + addr_t'(4);
        else if (ex_valid_i)  npc_d = trap_vector_base_i;
        else if (eret_i)      npc_d = epc_i;
        else if (mispredict)  npc_d = resolved_branch_i.target;
        else if (fresh)       npc_d = predict_address;
    end

    // in-flight bookkeeping
    always_comb begin
        outstanding_d = outstanding_q;
        stale_d       = stale_q;
        if (accept) begin
            outstanding_d = 1'b1;
            // issued with the old pc while redirecting
            stale_d       = kill;
        end else if (rsp_fire) begin
            outstanding_d = 1'b0;
            stale_d       = 1'b0;
        end else if (kill && outstanding_q) begin
            stale_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q) begin
            npc_q         <= boot_addr_i;
            run_q         <= 1'b0;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
        end else begin
            npc_q         <= npc_d;
            run_q         <= 1'b1;
            outstanding_q <= outstanding_d;
            stale_q       <= stale_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "frontend_params.svh"

module fetch_queue (
    input  logic                       clk_i,
    input  logic                       npc_rst_load_q,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  frontend_pkg::fetch_entry_t entry_i,
    output logic                       space_o,
    output frontend_pkg::fetch_entry_t fetch_entry_o,
    output logic                       fetch_valid_o,
    input  logic                       fetch_ready_i
);
    import frontend_pkg::*;

    localparam int unsigned DEPTH   = `FE_QUEUE_DEPTH;
    localparam int unsigned PTR_W   = $clog2(DEPTH);
    localparam int unsigned CNT_W   = $clog2(DEPTH + 1);

    // ------------------------------------------------------------------
    // storage and pointers
    // ------------------------------------------------------------------
    // payload only, occupancy lives in cnt_q
    fetch_entry_t mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] cnt_q, cnt_d;
    logic             pop;

    assign pop = fetch_valid_o && fetch_ready_i;

    // head of queue, held while decode stalls
    assign fetch_valid_o = (cnt_q != '0);
    assign fetch_entry_o = mem_q[rd_ptr_q];

    // two free slots, one for the answer already on its way
    assign space_o = (CNT_W'(DEPTH) - cnt_q) >= CNT_W'(2);

    always_comb begin
        cnt_d = cnt_q;
        if (push_i && !pop) cnt_d = cnt_q + CNT_W'(1);
        if (!push_i && pop) cnt_d = cnt_q - CNT_W'(1);
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // ------------------------------------------------------------------
    // control state
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            // pointers wrap at the power-of-two depth
            if (push_i) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            if (pop)    rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            cnt_q <= cnt_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/frontend.sv
`timescale 1ns/1ns
`default_nettype none

module frontend (
    input  logic                       clk_i,
    input  logic                       npc_rst_load_q,
    input  logic                       flush_i,
    input  frontend_pkg::addr_t        boot_addr_i,
    input  frontend_pkg::bp_resolve_t  resolved_branch_i,
    input  logic                       set_pc_commit_i,
    input  frontend_pkg::addr_t        pc_commit_i,
    input  logic                       eret_i,
    input  frontend_pkg::addr_t        epc_i,
    input  logic                       ex_valid_i,
    input  frontend_pkg::addr_t        trap_vector_base_i,
    output frontend_pkg::mem_req_t     mem_req_o,
    input  frontend_pkg::mem_rsp_t     mem_rsp_i,
    output frontend_pkg::fetch_entry_t fetch_entry_o,
    output logic                       fetch_valid_o,
    input  logic                       fetch_ready_i
);
    import frontend_pkg::*;

    // ------------------------------------------------------------------
    // internal wires
    // ------------------------------------------------------------------
    addr_t        fetch_addr;
    instr_t       fetch_instr;
    scan_t        scan;
    logic         bht_taken;
    logic         bht_valid;
    bht_update_t  bht_update;
    logic         queue_space;
    logic         push;
    fetch_entry_t push_entry;

    // pc register, prediction and memory handshake
    pc_gen i_pc_gen (
        .clk_i              (clk_i),
        .npc_rst_load_q     (npc_rst_load_q),
        .flush_i            (flush_i),
        .boot_addr_i        (boot_addr_i),
        .resolved_branch_i  (resolved_branch_i),
        .set_pc_commit_i    (set_pc_commit_i),
        .pc_commit_i        (pc_commit_i),
        .eret_i             (eret_i),
        .epc_i              (epc_i),
        .ex_valid_i         (ex_valid_i),
        .trap_vector_base_i (trap_vector_base_i),
        .mem_req_o          (mem_req_o),
        .mem_rsp_i          (mem_rsp_i),
        .scan_i             (scan),
        .bht_taken_i        (bht_taken),
        .bht_valid_i        (bht_valid),
        .queue_space_i      (queue_space),
        .fetch_addr_o       (fetch_addr),
        .fetch_instr_o      (fetch_instr),
        .push_o             (push),
        .push_entry_o       (push_entry),
        .bht_update_o       (bht_update)
    );

    // looks at the word straight off the memory bus
    instr_scan i_instr_scan (
        .instr_i (fetch_instr),
        .scan_o  (scan)
    );

    bht i_bht (
        .clk_i          (clk_i),
        .npc_rst_load_q (npc_rst_load_q),
        .flush_i        (flush_i),
        .vpc_i          (fetch_addr),
        .update_i       (bht_update),
        .taken_o        (bht_taken),
        .valid_o        (bht_valid)
    );

    // towards decode
    fetch_queue i_fetch_queue (
        .clk_i          (clk_i),
        .npc_rst_load_q (npc_rst_load_q),
        .flush_i        (flush_i),
        .push_i         (push),
        .entry_i        (push_entry),
        .space_o        (queue_space),
        .fetch_entry_o  (fetch_entry_o),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_ready_i  (fetch_ready_i)
    );

endmodule

`default_nettype wire

// File: testbench/frontend_props.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_props (
    input logic                       clk_i,
    input logic                       npc_rst_load_q,
    input logic                       flush_i,
    input frontend_pkg::mem_req_t     mem_req_o,
    input frontend_pkg::mem_rsp_t     mem_rsp_i,
    input frontend_pkg::fetch_entry_t fetch_entry_o,
    input logic                       fetch_valid_o,
    input logic                       fetch_ready_i
);
    import frontend_pkg::*;

    // request accepted and not yet answered
    logic busy_q;

    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q) begin
            busy_q <= 1'b0;
        end else if (mem_req_o.req && mem_rsp_i.ready) begin
            busy_q <= 1'b1;
        end else if (mem_rsp_i.valid) begin
            busy_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // decode handshake
    // ------------------------------------------------------------------
    // a stalled head entry holds, flush and reset excepted
    assert property (@(posedge clk_i)
        disable iff (npc_rst_load_q)
        (fetch_valid_o && !fetch_ready_i && !flush_i)
            |=> (fetch_valid_o && $stable(fetch_entry_o)))
        else $error("fetch entry changed while decode stalled");

    // ------------------------------------------------------------------
    // memory side
    // ------------------------------------------------------------------
    assert property (@(posedge clk_i) npc_rst_load_q |-> !mem_req_o.req)
        else $error("memory request raised during reset");

    assert property (@(posedge clk_i)
        disable iff (npc_rst_load_q)
        busy_q |-> !mem_req_o.req)
        else $error("second memory request while one is outstanding");

endmodule

bind frontend frontend_props props_i (
    .clk_i          (clk_i),
    .npc_rst_load_q (npc_rst_load_q),
    .flush_i        (flush_i),
    .mem_req_o      (mem_req_o),
    .mem_rsp_i      (mem_rsp_i),
    .fetch_entry_o  (fetch_entry_o),
    .fetch_valid_o  (fetch_valid_o),
    .fetch_ready_i  (fetch_ready_i)
);

`default_nettype wire

// File: testbench/tb_frontend.sv
`timescale 1ns/1ns
`default_nettype none

`include "frontend_params.svh"

module tb_frontend;
    import frontend_pkg::*;

    // ------------------------------------------------------------------
    // program image, see the memory model below
    // ------------------------------------------------------------------
    localparam addr_t BOOT_ADDR = 32'h0000_0100;
    // beq x0,x0,+32 at 0x100, forward
    localparam instr_t I_FWD_BR  = 32'h0200_0063;
    // beq x0,x0,-16 at 0x110, backward
    localparam instr_t I_BACK_BR = 32'hFE00_08E3;
    // jal x0,+16 at 0x120
    localparam instr_t I_JAL     = 32'h0100_006F;
    // jalr x0,0(x1) at 0x130
    localparam instr_t I_JALR    = 32'h0000_8067;
    localparam instr_t I_NOP     = 32'h0000_0013;

    logic         clk_i;
    logic         npc_rst_load_q;
    logic         flush_i;
    addr_t        boot_addr_i;
    bp_resolve_t  resolved_branch_i;
    logic         set_pc_commit_i;
    addr_t        pc_commit_i;
    logic         eret_i;
    addr_t        epc_i;
    logic         ex_valid_i;
    addr_t        trap_vector_base_i;
    mem_req_t     mem_req_o;
    mem_rsp_t     mem_rsp_i;
    fetch_entry_t fetch_entry_o;
    logic         fetch_valid_o;
    logic         fetch_ready_i;

    // scoreboard state
    addr_t       exp_addr;
    logic        trained;
    logic        want_taken_100;
    logic        pend_q;
    addr_t       pend_addr_q;
    int unsigned errors;
    int unsigned n_jal, n_jalr, n_fwd, n_back, n_trained;

    frontend frontend_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic instr_t mem_word(addr_t a);
        case (a)
            32'h100: return I_FWD_BR;
            32'h110: return I_BACK_BR;
            32'h120: return I_JAL;
            32'h130: return I_JALR;
            default: return I_NOP;
        endcase
    endfunction

    // control-flow class of each word in the program image
    function automatic cf_e exp_cf(addr_t a);
        case (a)
            32'h100: return BRANCH;
            32'h110: return BRANCH;
            32'h120: return JUMP;
            32'h130: return JUMPR;
            default: return NO_CF;
        endcase
    endfunction

    // expected prediction from the static rules and the training state
    function automatic logic exp_taken(addr_t a);
        case (a)
            32'h100: return trained;
            32'h110: return 1'b1;
            32'h120: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic addr_t exp_next(addr_t a);
        if (!exp_taken(a)) return a + 32'd4;
        case (a)
            32'h100: return 32'h120;
            32'h110: return 32'h100;
            default: return 32'h130;
        endcase
    endfunction

    task automatic report_mismatch(string name, logic [31:0] expv, logic [31:0] actv);
        errors++;
        $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expv, actv);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(string what);
        errors++;
        $display("[ERROR] t=%0t %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------
    // memory model, ready always high, answer one cycle after accept
    // ------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (npc_rst_load_q) begin
            pend_q <= 1'b0;
        end else begin
            pend_q      <= mem_req_o.req;
            pend_addr_q <= mem_req_o.vaddr;
        end
    end

    always @(negedge clk_i) begin
        mem_rsp_i.valid <= pend_q;
        mem_rsp_i.data  <= pend_q ? mem_word(pend_addr_q) : I_NOP;
    end

    // ------------------------------------------------------------------
    // checker on every accepted entry
    // ------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (!npc_rst_load_q) begin
            if (fetch_valid_o && fetch_ready_i) begin
                assert (fetch_entry_o.address == exp_addr)
                    else report_mismatch("fetch_entry_o.address", exp_addr,
                                         fetch_entry_o.address);
                assert (fetch_entry_o.instr == mem_word(exp_addr))
                    else report_mismatch("fetch_entry_o.instr", mem_word(exp_addr),
                                         fetch_entry_o.instr);
                assert (fetch_entry_o.cf_type == exp_cf(exp_addr))
                    else report_mismatch("fetch_entry_o.cf_type",
                                         32'(exp_cf(exp_addr)),
                                         32'(fetch_entry_o.cf_type));
                assert (fetch_entry_o.predict_taken == exp_taken(exp_addr))
                    else report_mismatch("fetch_entry_o.predict_taken",
                                         32'(exp_taken(exp_addr)),
                                         32'(fetch_entry_o.predict_taken));
                assert (fetch_entry_o.predict_address == exp_next(exp_addr))
                    else report_mismatch("fetch_entry_o.predict_address",
                                         exp_next(exp_addr), fetch_entry_o.predict_address);
                if (exp_addr == 32'h120) n_jal++;
                if (exp_addr == 32'h130) n_jalr++;
                if (exp_addr == 32'h110) n_back++;
                if (exp_addr == 32'h100 && !trained) n_fwd++;
                if (exp_addr == 32'h100 && want_taken_100) begin
                    n_trained++;
                    want_taken_100 = 1'b0;
                end
                exp_addr = exp_next(exp_addr);
            end
            // redirect priority, commit first and mispredict last
            if (set_pc_commit_i) exp_addr = pc_commit_i + 32'd4;
            else if (ex_valid_i) exp_addr = trap_vector_base_i;
            else if (eret_i) exp_addr = epc_i;
            else if (resolved_branch_i.valid && resolved_branch_i.is_mispredict)
                exp_addr = resolved_branch_i.target;
            if (flush_i) trained = 1'b0;
            if (resolved_branch_i.valid && resolved_branch_i.cf_type == BRANCH
                    && resolved_branch_i.pc == 32'h100 && resolved_branch_i.is_taken)
                trained = 1'b1;
        end
    end

    task automatic clear_redirects();
        flush_i           = 1'b0;
        set_pc_commit_i   = 1'b0;
        eret_i            = 1'b0;
        ex_valid_i        = 1'b0;
        resolved_branch_i = '0;
    endtask

    // one cycle of redirect inputs, then back to idle
    // every source points somewhere else, so only the winner lands on its address
    task automatic redirect(logic flush, logic commit, logic ex, logic eret,
                            logic misp, addr_t target);
        @(negedge clk_i);
        flush_i         = flush;
        set_pc_commit_i = commit;
        pc_commit_i     = target - 32'd4;
        ex_valid_i      = ex;
        trap_vector_base_i = target + 32'h10;
        eret_i          = eret;
        epc_i           = target + 32'h20;
        resolved_branch_i.valid         = misp;
        resolved_branch_i.is_mispredict = misp;
        resolved_branch_i.target        = target + 32'h30;
        resolved_branch_i.cf_type       = JUMPR;
        @(negedge clk_i);
        clear_redirects();
    endtask

    initial begin
        repeat (4000) @(posedge clk_i);
        $display("watchdog expired, the DUT stopped delivering entries");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    initial begin
        addr_t tgt;
        int unsigned kind;
        void'($urandom(21));
        npc_rst_load_q = 1'b1;
        boot_addr_i    = BOOT_ADDR;
        pc_commit_i    = '0;
        epc_i          = '0;
        trap_vector_base_i = '0;
        mem_rsp_i      = '{ready: 1'b1, valid: 1'b0, data: I_NOP};
        fetch_ready_i  = 1'b1;
        clear_redirects();
        exp_addr = BOOT_ADDR;
        trained = 1'b0;
        want_taken_100 = 1'b0;
        errors = 0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        npc_rst_load_q = 1'b0;
        // untrained loop 0x100..0x110
        repeat (40) @(negedge clk_i);
        // all redirect sources at once, commit wins
        redirect(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 32'h120);
        repeat (20) @(negedge clk_i);
        // trap vector over exception return
        redirect(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 32'h130);
        repeat (10) @(negedge clk_i);
        // exception return over mispredict
        redirect(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 32'h10C);
        repeat (10) @(negedge clk_i);
        // ---------------- train the forward branch as taken
        redirect(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 32'h100);
        resolved_branch_i = '{valid: 1'b1, pc: 32'h100, target: 32'h120,
                              is_taken: 1'b1, is_mispredict: 1'b0, cf_type: BRANCH};
        @(negedge clk_i);
        clear_redirects();
        redirect(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h100);
        want_taken_100 = 1'b1;
        repeat (30) @(negedge clk_i);
        // ---------------- random back-pressure and flushes
        repeat (600) begin
            @(negedge clk_i);
            fetch_ready_i = 1'($urandom % 2);
            if ($urandom % 16 == 0) begin
                tgt  = 32'h100 + (($urandom % 16) << 2);
                kind = $urandom % 4;
                redirect(1'b1, kind == 0, kind == 1, kind == 2, kind == 3, tgt);
            end
        end
        @(negedge clk_i);
        fetch_ready_i = 1'b1;
        repeat (10) @(negedge clk_i);
        if (n_jal == 0 || n_jalr == 0 || n_fwd == 0 || n_back == 0 || n_trained == 0)
            report_failure("not every control-flow case reached the decode side");
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
hdl/frontend_pkg.sv
hdl/instr_scan.sv
hdl/bht.sv
hdl/pc_gen.sv
hdl/fetch_queue.sv
hdl/frontend.sv
testbench/frontend_props.sv
testbench/tb_frontend.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the frontend testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_frontend \
    -f tb.f \
    -o Vtb_frontend

# the simulator exits non-zero on a failure, the log decides
./obj_dir/Vtb_frontend > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
